// File: include/uart_rx_settings.svh
`ifndef UART_RX_SETTINGS_SVH
`define UART_RX_SETTINGS_SVH

// ------------------------------------------------------------
// Receive channel timing
// ------------------------------------------------------------

// Oversampling ticks per bit, the counter wraps at a power of two
`define RX_OVERSAMPLE 16
// System clocks per oversampling tick, so one bit lasts 64 clocks
`define RX_TICK_DIV 4

// ------------------------------------------------------------
// Receive FIFO geometry
// ------------------------------------------------------------

`define RX_FIFO_DEPTH 16
`define RX_FIFO_AW 4
// Wide enough to hold a threshold equal to the full depth
`define RX_THRESH_W 5

`endif

// File: verilog/uart_cfg_pkg.sv
`include "uart_rx_settings.svh"

package uart_cfg_pkg;

    // ------------------------------------------------------------
    // Line format, set by the host
    // ------------------------------------------------------------

    // Number of data bits in one character
    typedef enum logic [1:0] {
        DW_5BIT,
        DW_6BIT,
        DW_7BIT,
        DW_8BIT
    } data_width_e;

    // The fourth encoding is left unused and behaves as no check
    typedef enum logic [1:0] {
        PAR_NONE,
        PAR_EVEN,
        PAR_ODD
    } parity_e;

    typedef enum logic {
        SB_1BIT,
        SB_2BIT
    } stop_bits_e;

    // FIFO level that raises data ready in stream mode, zero means full
    typedef logic [`RX_THRESH_W-1:0] rx_threshold_t;

endpackage

// File: verilog/uart_rx_pkg.sv
`include "uart_rx_settings.svh"

package uart_rx_pkg;

    // ------------------------------------------------------------
    // Frame receiver states
    // ------------------------------------------------------------

    typedef enum logic [2:0] {
        // Line idle, waiting for a falling edge
        RX_IDLE,
        // Counting to the middle of the start bit
        RX_START,
        // Shifting in the data bits
        RX_SAMPLE,
        RX_PARITY,
        // One or two stop bits
        RX_STOP
    } rx_state_e;

    // ------------------------------------------------------------
    // FIFO entry and occupancy
    // ------------------------------------------------------------

    // Data is right aligned, bits above the character width are zero
    typedef struct packed {
        logic [7:0] data;
        logic       frame_err;
        logic       parity_err;
    } rx_entry_t;

    // One bit wider than the address so that a full FIFO can be counted
    typedef logic [`RX_FIFO_AW:0] fifo_count_t;

endpackage

// File: verilog/rx_baud_tick.sv
`include "uart_rx_settings.svh"

module rx_baud_tick (
    input  logic clk_i,
    input  logic rst_n_i,
    output logic os_tick_o
);

    // A divisor of one still needs a counter of at least one bit
    localparam int DIV_W = (`RX_TICK_DIV > 1) ? $clog2(`RX_TICK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`RX_TICK_DIV - 1);

    logic [DIV_W-1:0] div_cnt;

    // The tick is registered and lasts exactly one clock per period
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_cnt   <= '0;
            os_tick_o <= 1'b0;
        end else if (div_cnt == DIV_LAST) begin
            div_cnt   <= '0;
            os_tick_o <= 1'b1;
        end else begin
            div_cnt   <= div_cnt + 1'b1;
            os_tick_o <= 1'b0;
        end
    end

endmodule

// File: verilog/rx_frame_fsm.sv
`include "uart_rx_settings.svh"

module rx_frame_fsm import uart_cfg_pkg::*, uart_rx_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        rx_i,
    input  logic        os_tick_i,
    input  data_width_e data_width_i,
    input  parity_e     parity_mode_i,
    input  stop_bits_e  stop_bits_i,
    output logic        frame_valid_o,
    output rx_entry_t   frame_entry_o,
    output logic        rx_idle_o
);

    localparam int OS_W = $clog2(`RX_OVERSAMPLE);
    // Last tick of a bit period and the tick that centres the start bit
    localparam logic [OS_W-1:0] OS_LAST = OS_W'(`RX_OVERSAMPLE - 1);
    localparam logic [OS_W-1:0] OS_MID  = OS_W'(`RX_OVERSAMPLE / 2 - 1);

    logic            rx_meta;
    logic            rx_sync;
    rx_state_e       state;
    logic [OS_W-1:0] os_cnt;
    logic [2:0]      bit_cnt;
    logic [2:0]      last_bit;
    logic            second_stop;
    logic            stop_err;
    logic [7:0]      shift_reg;
    logic            parity_bit;
    logic [7:0]      aligned;
    logic            data_par;
    logic            sample_pt;
    logic            mid_start;
    logic            last_stop;

    // ------------------------------------------------------------
    // Line synchronizer
    // ------------------------------------------------------------

    // Both flops come out of reset at the idle line level
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    // ------------------------------------------------------------
    // Frame state machine
    // ------------------------------------------------------------

    // Once centred on the start bit, every OS_LAST tick is mid bit
    assign sample_pt = os_tick_i && (os_cnt == OS_LAST);
    assign mid_start = os_tick_i && (os_cnt == OS_MID);
    // Index of the final data bit, 4 for five bits up to 7 for eight
    assign last_bit  = 3'd4 + 3'(data_width_i);
    assign last_stop = (state == RX_STOP) && sample_pt &&
                       ((stop_bits_i == SB_1BIT) || second_stop);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= RX_IDLE;
            os_cnt      <= '0;
            bit_cnt     <= '0;
            second_stop <= 1'b0;
            stop_err    <= 1'b0;
        end else begin
            // Free running bit timer, individual states override it
            if (os_tick_i) begin
                os_cnt <= (os_cnt == OS_LAST) ? '0 : os_cnt + 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    os_cnt      <= '0;
                    second_stop <= 1'b0;
                    stop_err    <= 1'b0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (mid_start) begin
                        os_cnt  <= '0;
                        bit_cnt <= '0;
                        // A line that is high again by now was only a glitch
                        if (rx_sync) begin
                            state <= RX_IDLE;
                        end else begin
                            state <= RX_SAMPLE;
                        end
                    end
                end
                RX_SAMPLE: begin
                    if (sample_pt) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == last_bit) begin
                            if (parity_mode_i == PAR_NONE) begin
                                state <= RX_STOP;
                            end else begin
                                state <= RX_PARITY;
                            end
                        end
                    end
                end
                RX_PARITY: begin
                    if (sample_pt) begin
                        state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (last_stop) begin
                        state <= RX_IDLE;
                    end else if (sample_pt) begin
                        // First of two stop bits, remember a low sample
                        second_stop <= 1'b1;
                        stop_err    <= ~rx_sync;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Character datapath
    // ------------------------------------------------------------

    // LSB arrives first, so each bit enters at the top and moves down
    always_ff @(posedge clk_i) begin
        if ((state == RX_SAMPLE) && sample_pt) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
        if ((state == RX_PARITY) && sample_pt) begin
            parity_bit <= rx_sync;
        end
    end

    always_comb begin
        // Narrow characters sit in the top of the shift register
        case (data_width_i)
            DW_5BIT: aligned = {3'b000, shift_reg[7:3]};
            DW_6BIT: aligned = {2'b00, shift_reg[7:2]};
            DW_7BIT: aligned = {1'b0, shift_reg[7:1]};
            default: aligned = shift_reg;
        endcase
        // Zero fill keeps the XOR over all eight bits correct
        data_par = ^aligned;
        frame_entry_o.data = aligned;
        // The entry is taken in the cycle of the last stop sample
        frame_entry_o.frame_err = stop_err | ~rx_sync;
        case (parity_mode_i)
            PAR_EVEN: frame_entry_o.parity_err = data_par ^ parity_bit;
            PAR_ODD:  frame_entry_o.parity_err = ~(data_par ^ parity_bit);
            default:  frame_entry_o.parity_err = 1'b0;
        endcase
    end

    assign frame_valid_o = last_stop;
    assign rx_idle_o     = (state == RX_IDLE);

endmodule

// File: verilog/rx_fifo.sv
`include "uart_rx_settings.svh"

module rx_fifo import uart_rx_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        push_i,
    input  logic        pop_i,
    input  rx_entry_t   wr_entry_i,
    output rx_entry_t   rd_entry_o,
    output logic        full_o,
    output logic        empty_o,
    output fifo_count_t count_o
);

    localparam logic [`RX_FIFO_AW-1:0] PTR_LAST = `RX_FIFO_AW'(`RX_FIFO_DEPTH - 1);

    rx_entry_t               mem [`RX_FIFO_DEPTH];
    logic [`RX_FIFO_AW-1:0]  wr_ptr;
    logic [`RX_FIFO_AW-1:0]  rd_ptr;
    fifo_count_t             count;
    logic                    do_push;
    logic                    do_pop;

    // Requests that would overflow or underflow are ignored
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_entry_i;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry is visible without a read latency
    assign rd_entry_o = mem[rd_ptr];
    assign full_o     = (count == fifo_count_t'(`RX_FIFO_DEPTH));
    assign empty_o    = (count == '0);
    assign count_o    = count;

endmodule

// File: verilog/rx_host_port.sv
`include "uart_rx_settings.svh"

module rx_host_port import uart_cfg_pkg::*, uart_rx_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          frame_valid_i,
    input  logic          stream_mode_i,
    input  rx_threshold_t threshold_i,
    input  logic          fifo_full_i,
    input  logic          fifo_empty_i,
    input  fifo_count_t   fifo_count_i,
    input  rx_entry_t     fifo_entry_i,
    input  logic          rd_req_i,
    output logic          fifo_push_o,
    output logic          fifo_pop_o,
    output logic          rd_ack_o,
    output logic [7:0]    rd_data_o,
    output logic          frame_err_o,
    output logic          parity_err_o,
    output logic          overrun_o,
    output logic          data_ready_o
);

    logic        req_q;
    logic        read_done;
    fifo_count_t count_after;
    logic        ready_hit;

    // ------------------------------------------------------------
    // Write side and data ready
    // ------------------------------------------------------------

    // A frame that finds the FIFO full is lost
    assign fifo_push_o = frame_valid_i & ~fifo_full_i;
    // Level the FIFO will have once this push and any pop settle
    assign count_after = fifo_count_i + fifo_count_t'(1) - fifo_count_t'(fifo_pop_o);

    always_comb begin
        if (!stream_mode_i) begin
            ready_hit = 1'b1;
        end else if (threshold_i != '0) begin
            ready_hit = (count_after == fifo_count_t'(threshold_i));
        end else begin
            // Zero threshold waits for the push that fills the FIFO
            ready_hit = (count_after == fifo_count_t'(`RX_FIFO_DEPTH));
        end
    end

    // ------------------------------------------------------------
    // Four-phase read
    // ------------------------------------------------------------

    // Pop once per request, on the clock after it is seen high
    assign fifo_pop_o = req_q & ~rd_ack_o & ~fifo_empty_i;
    // Request gone while ack is still up ends the read
    assign read_done  = ~req_q & rd_ack_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q        <= 1'b0;
            rd_ack_o     <= 1'b0;
            overrun_o    <= 1'b0;
            data_ready_o <= 1'b0;
        end else begin
            req_q        <= rd_req_i;
            data_ready_o <= fifo_push_o & ready_hit;
            if (fifo_pop_o) begin
                rd_ack_o <= 1'b1;
            end else if (read_done) begin
                rd_ack_o <= 1'b0;
            end
            // A new drop outranks a read that completes in the same clock
            if (frame_valid_i && fifo_full_i) begin
                overrun_o <= 1'b1;
            end else if (read_done) begin
                overrun_o <= 1'b0;
            end
        end
    end

    // Held from the pop until the next pop, so stable while ack is high
    always_ff @(posedge clk_i) begin
        if (fifo_pop_o) begin
            rd_data_o    <= fifo_entry_i.data;
            frame_err_o  <= fifo_entry_i.frame_err;
            parity_err_o <= fifo_entry_i.parity_err;
        end
    end

endmodule

// File: verilog/uart_rx_top.sv
module uart_rx_top import uart_cfg_pkg::*, uart_rx_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          rx_i,
    input  data_width_e   data_width_i,
    input  parity_e       parity_mode_i,
    input  stop_bits_e    stop_bits_i,
    input  logic          stream_mode_i,
    input  rx_threshold_t threshold_i,
    input  logic          rd_req_i,
    output logic          rd_ack_o,
    output logic [7:0]    rd_data_o,
    output logic          frame_err_o,
    output logic          parity_err_o,
    output logic          overrun_o,
    output logic          data_ready_o,
    output logic          fifo_empty_o,
    output logic          rx_idle_o
);

    logic        os_tick;
    logic        frame_valid;
    rx_entry_t   frame_entry;
    rx_entry_t   fifo_entry;
    logic        fifo_push;
    logic        fifo_pop;
    logic        fifo_full;
    fifo_count_t fifo_count;

    // ------------------------------------------------------------
    // Serial side
    // ------------------------------------------------------------

    rx_baud_tick u_baud_tick (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .os_tick_o (os_tick)
    );

    rx_frame_fsm u_frame_fsm (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rx_i          (rx_i),
        .os_tick_i     (os_tick),
        .data_width_i  (data_width_i),
        .parity_mode_i (parity_mode_i),
        .stop_bits_i   (stop_bits_i),
        .frame_valid_o (frame_valid),
        .frame_entry_o (frame_entry),
        .rx_idle_o     (rx_idle_o)
    );

    // ------------------------------------------------------------
    // Buffer and host side
    // ------------------------------------------------------------

    // The entry goes straight in, the host port only decides the push
    rx_fifo u_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .push_i     (fifo_push),
        .pop_i      (fifo_pop),
        .wr_entry_i (frame_entry),
        .rd_entry_o (fifo_entry),
        .full_o     (fifo_full),
        .empty_o    (fifo_empty_o),
        .count_o    (fifo_count)
    );

    rx_host_port u_host_port (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .frame_valid_i (frame_valid),
        .stream_mode_i (stream_mode_i),
        .threshold_i   (threshold_i),
        .fifo_full_i   (fifo_full),
        .fifo_empty_i  (fifo_empty_o),
        .fifo_count_i  (fifo_count),
        .fifo_entry_i  (fifo_entry),
        .rd_req_i      (rd_req_i),
        .fifo_push_o   (fifo_push),
        .fifo_pop_o    (fifo_pop),
        .rd_ack_o      (rd_ack_o),
        .rd_data_o     (rd_data_o),
        .frame_err_o   (frame_err_o),
        .parity_err_o  (parity_err_o),
        .overrun_o     (overrun_o),
        .data_ready_o  (data_ready_o)
    );

endmodule

// File: tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Reset is held for ten cycles and released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: tb/tb_uart_rx.sv
`include "uart_rx_settings.svh"

module tb_uart_rx import uart_cfg_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 40;
    localparam int BIT_CLKS      = `RX_OVERSAMPLE * `RX_TICK_DIV;
    localparam int FIFO_DEPTH    = `RX_FIFO_DEPTH;
    // Every frame that the tests below send
    localparam int NUM_FRAMES    = 57;
    // Twelve bit times per frame, with a factor of two for the reads
    localparam longint WATCHDOG_NS =
        longint'(NUM_FRAMES) * 12 * BIT_CLKS * CLK_PERIOD_NS * 2;

    logic          clk;
    logic          rst_n;
    logic          rx;
    data_width_e   data_width;
    parity_e       parity_mode;
    stop_bits_e    stop_bits;
    logic          stream_mode;
    rx_threshold_t threshold;
    logic          rd_req;
    logic          rd_ack;
    logic [7:0]    rd_data;
    logic          frame_err;
    logic          parity_err;
    logic          overrun;
    logic          data_ready;
    logic          fifo_empty;
    logic          rx_idle;

    logic [31:0]   lfsr_state;
    // Entries the FIFO should hold, as {data, frame_err, parity_err}
    logic [9:0]    exp_q[$];
    logic          overrun_model;
    int            ready_pulses = 0;
    int            proto_errors = 0;
    int            checks = 0;
    int            errors = 0;
    int            test_errors_base = 0;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    uart_rx_top uut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .rx_i          (rx),
        .data_width_i  (data_width),
        .parity_mode_i (parity_mode),
        .stop_bits_i   (stop_bits),
        .stream_mode_i (stream_mode),
        .threshold_i   (threshold),
        .rd_req_i      (rd_req),
        .rd_ack_o      (rd_ack),
        .rd_data_o     (rd_data),
        .frame_err_o   (frame_err),
        .parity_err_o  (parity_err),
        .overrun_o     (overrun),
        .data_ready_o  (data_ready),
        .fifo_empty_o  (fifo_empty),
        .rx_idle_o     (rx_idle)
    );

    // ------------------------------------------------------------
    // Read port protocol and data ready
    // ------------------------------------------------------------

    // An acknowledge only ever answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rd_ack) |-> $past(rd_req))
    else begin
        proto_errors++;
        $display("rd_ack_o rose although no read request was pending");
    end

    ack_held_for_req: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(rd_ack) |-> !$past(rd_req))
    else begin
        proto_errors++;
        $display("rd_ack_o fell while the read request was still high");
    end

    // Request seen low, ack drops one clock later
    ack_released: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rd_ack && !rd_req, 2) |-> !rd_ack)
    else begin
        proto_errors++;
        $display("rd_ack_o stayed high after the read request was dropped");
    end

    data_held: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_ack && $past(rd_ack)) |-> $stable({rd_data, frame_err, parity_err}))
    else begin
        proto_errors++;
        $display("Read data changed while rd_ack_o was high");
    end

    ready_single: assert property (@(posedge clk) disable iff (!rst_n)
        $past(data_ready) |-> !data_ready)
    else begin
        proto_errors++;
        $display("data_ready_o stayed high for more than one clock");
    end

    // Each pulse is one clock wide, so every falling edge sees it once
    always @(negedge clk) begin
        if (rst_n && data_ready) begin
            ready_pulses++;
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    // Galois form, shifting right with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 32'h8020_0003;
        end
        return nxt;
    endfunction

    // Bits above the width stay zero
    task automatic take_bits(input int nbits, output logic [7:0] value);
        int i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            value[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("Error %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic drive_bit(input logic value, input int clocks);
        rx = value;
        repeat (clocks) @(negedge clk);
    endtask

    task automatic send_frame(input logic [7:0] data, input int nbits, input parity_e par,
                              input stop_bits_e stops, input logic bad_par,
                              input logic [1:0] low_stop);
        int   i;
        int   nstop;
        logic par_bit;
        logic frame_bad;
        data_width  = data_width_e'(2'(nbits - 5));
        parity_mode = par;
        stop_bits   = stops;
        nstop       = (stops == SB_2BIT) ? 2 : 1;
        // Even parity makes data and parity bit XOR to zero, odd to one
        par_bit     = (^data) ^ (par == PAR_ODD) ^ bad_par;
        frame_bad   = 1'b0;
        drive_bit(1'b0, BIT_CLKS);
        for (i = 0; i < nbits; i++) begin
            drive_bit(data[i], BIT_CLKS);
        end
        if (par != PAR_NONE) begin
            drive_bit(par_bit, BIT_CLKS);
        end
        for (i = 0; i < nstop; i++) begin
            if (low_stop[i]) begin
                // Low across the sample point, then high again early enough
                // that the receiver rejects the edge as a glitch
                drive_bit(1'b0, BIT_CLKS * 3 / 4);
                drive_bit(1'b1, BIT_CLKS - BIT_CLKS * 3 / 4);
                frame_bad = 1'b1;
            end else begin
                drive_bit(1'b1, BIT_CLKS);
            end
        end
        // A frame that meets a full FIFO is lost and raises overrun
        if (exp_q.size() < FIFO_DEPTH) begin
            exp_q.push_back({data, frame_bad, bad_par && (par != PAR_NONE)});
        end else begin
            overrun_model = 1'b1;
        end
    endtask

    task automatic send_random(input int nbits, input parity_e par, input stop_bits_e stops);
        logic [7:0] data;
        take_bits(nbits, data);
        send_frame(data, nbits, par, stops, 1'b0, 2'b00);
    endtask

    // Four-phase read of one entry
    task automatic read_entry(input string name);
        logic [9:0] expected;
        logic [9:0] actual;
        while (fifo_empty) begin
            @(negedge clk);
        end
        rd_req = 1'b1;
        do begin
            @(negedge clk);
        end while (!rd_ack);
        actual = {rd_data, frame_err, parity_err};
        if (exp_q.size() == 0) begin
            errors++;
            $display("Read in test %s returned an entry that no frame produced", name);
        end else begin
            expected = exp_q.pop_front();
            check_value(name, 32'(expected), 32'(actual));
        end
        rd_req = 1'b0;
        do begin
            @(negedge clk);
        end while (rd_ack);
        overrun_model = 1'b0;
    endtask

    task automatic drain(input string name);
        while (exp_q.size() > 0) begin
            read_entry(name);
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished with %0d errors", name,
                 errors + proto_errors - test_errors_base);
        test_errors_base = errors + proto_errors;
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------

    initial begin
        logic [7:0] data;
        int         ready_base;
        int         total;
        rx            = 1'b1;
        rd_req        = 1'b0;
        data_width    = DW_8BIT;
        parity_mode   = PAR_NONE;
        stop_bits     = SB_1BIT;
        stream_mode   = 1'b0;
        threshold     = '0;
        lfsr_state    = 32'h9230_b992;
        overrun_model = 1'b0;
        wait (rst_n);
        @(negedge clk);

        check_value("reset_ack", 0, 32'(rd_ack));
        check_value("reset_data_ready", 0, 32'(data_ready));
        check_value("reset_overrun", 0, 32'(overrun));
        check_value("reset_fifo_empty", 1, 32'(fifo_empty));
        check_value("reset_rx_idle", 1, 32'(rx_idle));
        finish_test("reset_state");

        repeat (8) send_random(8, PAR_NONE, SB_1BIT);
        drain("data_8n1");
        finish_test("data_8n1");

        // Good and inverted parity bit for each mode
        take_bits(7, data);
        send_frame(data, 7, PAR_EVEN, SB_1BIT, 1'b0, 2'b00);
        take_bits(7, data);
        send_frame(data, 7, PAR_EVEN, SB_1BIT, 1'b1, 2'b00);
        take_bits(7, data);
        send_frame(data, 7, PAR_ODD, SB_1BIT, 1'b0, 2'b00);
        take_bits(7, data);
        send_frame(data, 7, PAR_ODD, SB_1BIT, 1'b1, 2'b00);
        drain("parity_7bit");
        finish_test("parity_7bit");

        take_bits(5, data);
        send_frame(data, 5, PAR_NONE, SB_2BIT, 1'b0, 2'b00);
        take_bits(5, data);
        send_frame(data, 5, PAR_NONE, SB_2BIT, 1'b0, 2'b01);
        take_bits(5, data);
        send_frame(data, 5, PAR_NONE, SB_2BIT, 1'b0, 2'b10);
        take_bits(5, data);
        send_frame(data, 5, PAR_NONE, SB_2BIT, 1'b0, 2'b00);
        drain("stop_bits");
        finish_test("stop_bits");

        // One frame more than the FIFO holds, with nobody reading
        repeat (FIFO_DEPTH) send_random(8, PAR_NONE, SB_1BIT);
        check_value("overrun_before_drop", 0, 32'(overrun));
        send_random(8, PAR_NONE, SB_1BIT);
        check_value("overrun_after_drop", 32'(overrun_model), 32'(overrun));
        read_entry("overrun");
        check_value("overrun_after_read", 32'(overrun_model), 32'(overrun));
        drain("overrun");
        finish_test("overrun");

        stream_mode = 1'b1;
        threshold   = rx_threshold_t'(3);
        ready_base  = ready_pulses;
        repeat (2) send_random(8, PAR_NONE, SB_1BIT);
        check_value("stream_thr3_two", 0, 32'(ready_pulses - ready_base));
        send_random(8, PAR_NONE, SB_1BIT);
        check_value("stream_thr3_three", 1, 32'(ready_pulses - ready_base));
        repeat (2) send_random(8, PAR_NONE, SB_1BIT);
        check_value("stream_thr3_five", 1, 32'(ready_pulses - ready_base));
        drain("stream_thr3");
        // Zero threshold waits for the push that fills the FIFO
        threshold  = '0;
        ready_base = ready_pulses;
        repeat (FIFO_DEPTH - 1) send_random(8, PAR_NONE, SB_1BIT);
        check_value("stream_thr0_almost", 0, 32'(ready_pulses - ready_base));
        send_random(8, PAR_NONE, SB_1BIT);
        check_value("stream_thr0_full", 1, 32'(ready_pulses - ready_base));
        drain("stream_thr0");
        stream_mode = 1'b0;
        ready_base  = ready_pulses;
        repeat (3) send_random(8, PAR_NONE, SB_1BIT);
        check_value("ready_per_frame", 3, 32'(ready_pulses - ready_base));
        drain("ready_per_frame");
        finish_test("stream_threshold");

        $display("Test handshake finished with %0d errors", proto_errors);
        total = errors + proto_errors;
        $display("Checks %0d, errors %0d", checks, total);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Regression failed");
        $finish;
    end

endmodule

// File: all.f
+incdir+include
verilog/uart_cfg_pkg.sv
verilog/uart_rx_pkg.sv
verilog/rx_baud_tick.sv
verilog/rx_frame_fsm.sv
verilog/rx_fifo.sv
verilog/rx_host_port.sv
verilog/uart_rx_top.sv
tb/tb_clock_gen.sv
tb/tb_uart_rx.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_uart_rx
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
